//--- src/fpu_pkg.sv
// fpu package: number format, operation codes, bus register map and constants
`default_nettype none

package fpu_pkg;

  localparam int EXP_BIAS  = 127;
  localparam int FRAC_W    = 23;
  localparam int MANT_W    = 24;
  localparam int MUL_STEPS = 24;

  // ieee single precision layout
  typedef struct packed {
    logic              sign;
    logic [7:0]        exp;
    logic [FRAC_W-1:0] frac;
  } fp32_t;

  // codes missing here execute as add
  typedef enum logic [3:0] {
    op_add     = 4'd0,
    op_sub     = 4'd1,
    op_mul     = 4'd2,
    op_k_pi    = 4'd5,
    op_k_piby2 = 4'd6
  } fpu_op_e;

  // one host bus cycle, selects active low
  typedef struct packed {
    logic       cs_n;
    logic       rd_n;
    logic       wr_n;
    logic [3:0] addr;
    logic [7:0] wdata;
  } bus_req_t;

  // register map, byte 0 is the least significant
  localparam logic [3:0] ADDR_A0 = 4'd0;
  localparam logic [3:0] ADDR_A1 = 4'd1;
  localparam logic [3:0] ADDR_A2 = 4'd2;
  localparam logic [3:0] ADDR_A3 = 4'd3;
  localparam logic [3:0] ADDR_B0 = 4'd4;
  localparam logic [3:0] ADDR_B1 = 4'd5;
  localparam logic [3:0] ADDR_B2 = 4'd6;
  localparam logic [3:0] ADDR_B3 = 4'd7;
  localparam logic [3:0] ADDR_OP = 4'd8;
  localparam logic [3:0] ADDR_R0 = 4'd9;
  localparam logic [3:0] ADDR_R1 = 4'd10;
  localparam logic [3:0] ADDR_R2 = 4'd11;
  localparam logic [3:0] ADDR_R3 = 4'd12;

  // truncated constants
  localparam fp32_t K_PI      = 32'h40490fda;
  localparam fp32_t K_PI_BY_2 = 32'h3fc90fda;
  localparam fp32_t K_ONE     = 32'h3f800000;

endpackage

`default_nettype wire

//--- src/fpu_bus_regs.sv
// fpu bus registers: byte-wide host access to operands, operation and result
`timescale 1ns/1ps
`default_nettype none

module fpu_bus_regs (
  input  logic              clk,
  input  logic              arst,
  input  fpu_pkg::bus_req_t bus_req,
  input  fpu_pkg::fp32_t    result,
  input  logic              result_load,
  output logic [7:0]        rdata,
  output fpu_pkg::fp32_t    operand_a,
  output fpu_pkg::fp32_t    operand_b,
  output fpu_pkg::fpu_op_e  operation,
  output logic              op_strobe
);
  import fpu_pkg::*;

  fp32_t result_reg;
  logic  wr_en;
  logic  rd_en;

  // unknown codes fold to add
  function automatic fpu_op_e decode_op(input logic [3:0] code);
    fpu_op_e op;
    case (code)
      op_sub, op_mul, op_k_pi, op_k_piby2: op = fpu_op_e'(code);
      default: op = op_add;
    endcase
    return op;
  endfunction

  assign wr_en = !bus_req.cs_n && !bus_req.wr_n;
  assign rd_en = !bus_req.cs_n && !bus_req.rd_n;

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      operand_a  <= K_ONE;
      operand_b  <= K_ONE;
      operation  <= op_add;
      result_reg <= '0;
      op_strobe  <= 1'b0;
    end else begin
      op_strobe <= wr_en && (bus_req.addr == ADDR_OP);
      if (wr_en) begin
        case (bus_req.addr)
          ADDR_A0: operand_a[7:0]   <= bus_req.wdata;
          ADDR_A1: operand_a[15:8]  <= bus_req.wdata;
          ADDR_A2: operand_a[23:16] <= bus_req.wdata;
          ADDR_A3: operand_a[31:24] <= bus_req.wdata;
          ADDR_B0: operand_b[7:0]   <= bus_req.wdata;
          ADDR_B1: operand_b[15:8]  <= bus_req.wdata;
          ADDR_B2: operand_b[23:16] <= bus_req.wdata;
          ADDR_B3: operand_b[31:24] <= bus_req.wdata;
          ADDR_OP: operation        <= decode_op(bus_req.wdata[3:0]);
          default: begin
          end
        endcase
      end
      // result also lands in A so operations can chain
      if (result_load) begin
        result_reg <= result;
        operand_a  <= result;
      end
    end
  end

  // read mux, zero when not selected
  always_comb begin
    rdata = 8'h00;
    if (rd_en) begin
      case (bus_req.addr)
        ADDR_A0: rdata = operand_a[7:0];
        ADDR_A1: rdata = operand_a[15:8];
        ADDR_A2: rdata = operand_a[23:16];
        ADDR_A3: rdata = operand_a[31:24];
        ADDR_B0: rdata = operand_b[7:0];
        ADDR_B1: rdata = operand_b[15:8];
        ADDR_B2: rdata = operand_b[23:16];
        ADDR_B3: rdata = operand_b[31:24];
        ADDR_OP: rdata = {4'h0, operation};
        ADDR_R0: rdata = result_reg[7:0];
        ADDR_R1: rdata = result_reg[15:8];
        ADDR_R2: rdata = result_reg[23:16];
        ADDR_R3: rdata = result_reg[31:24];
        default: rdata = 8'h00;
      endcase
    end
  end

  // host writes to A never collide with a result being loaded
  a_write_vs_load: assert property (@(posedge clk) disable iff (arst)
    result_load |-> !(wr_en && (bus_req.addr <= ADDR_A3)))
    else $error("operand A written in the same cycle as result_load");

endmodule

`default_nettype wire

//--- src/fpu_add_sub.sv
// fpu adder: aligns, sums and normalises two single precision operands
`timescale 1ns/1ps
`default_nettype none

module fpu_add_sub (
  input  fpu_pkg::fp32_t operand_a,
  input  fpu_pkg::fp32_t operand_b,
  input  logic           subtract,
  output fpu_pkg::fp32_t sum_result
);
  import fpu_pkg::*;

  // carry bit plus sign bit above the mantissa
  localparam int SUM_W = MANT_W + 2;

  logic              b_zero;
  logic              a_zero;
  logic [MANT_W-1:0] mant_a;
  logic [MANT_W-1:0] mant_b;
  logic [MANT_W-1:0] align_a;
  logic [MANT_W-1:0] align_b;
  logic [7:0]        exp_big;
  logic [7:0]        exp_diff;
  logic [SUM_W-1:0]  signed_a;
  logic [SUM_W-1:0]  signed_b;
  logic [SUM_W-1:0]  sum;
  logic [SUM_W-1:0]  mag;
  logic [MANT_W-1:0] norm;
  logic [4:0]        lead_zeros;
  logic [7:0]        exp_out;

  // zeros above the first one
  function automatic logic [4:0] count_lz(input logic [MANT_W-1:0] value);
    logic [4:0] count;
    logic       found;
    count = '0;
    found = 1'b0;
    for (int i = MANT_W - 1; i >= 0; i--) begin
      if (value[i]) begin
        found = 1'b1;
      end else if (!found) begin
        count = count + 5'd1;
      end
    end
    return count;
  endfunction

  assign a_zero = (operand_a.exp == 8'd0) && (operand_a.frac == '0);
  assign b_zero = (operand_b.exp == 8'd0) && (operand_b.frac == '0);

  // hidden bit back in front of the fraction
  assign mant_a = {|operand_a.exp, operand_a.frac};
  assign mant_b = {|operand_b.exp, operand_b.frac};

  // shift the smaller operand down to the larger exponent
  always_comb begin
    if (operand_a.exp >= operand_b.exp) begin
      exp_big  = operand_a.exp;
      exp_diff = operand_a.exp - operand_b.exp;
      align_a  = mant_a;
      align_b  = b_zero ? mant_b : (mant_b >> exp_diff);
    end else begin
      exp_big  = operand_b.exp;
      exp_diff = operand_b.exp - operand_a.exp;
      align_a  = a_zero ? mant_a : (mant_a >> exp_diff);
      align_b  = mant_b;
    end
  end

  assign signed_a = operand_a.sign ? (~{2'b00, align_a} + SUM_W'(1)) : {2'b00, align_a};
  assign signed_b = operand_b.sign ? (~{2'b00, align_b} + SUM_W'(1)) : {2'b00, align_b};
  assign sum      = subtract ? (signed_a - signed_b) : (signed_a + signed_b);

  always_comb begin
    mag        = sum[SUM_W-1] ? (~sum + SUM_W'(1)) : sum;
    lead_zeros = count_lz(mag[MANT_W-1:0]);
    // carry out of the mantissa moves the point right
    if (mag[SUM_W-1]) begin
      norm    = mag[SUM_W-1:2];
      exp_out = exp_big + 8'd2;
    end else if (mag[SUM_W-2]) begin
      norm    = mag[SUM_W-2:1];
      exp_out = exp_big + 8'd1;
    end else begin
      norm    = mag[MANT_W-1:0] << lead_zeros;
      exp_out = exp_big - {3'b000, lead_zeros};
    end
    // exact cancellation always gives +0
    if (sum == '0) begin
      sum_result = '0;
    end else begin
      sum_result.sign = sum[SUM_W-1];
      sum_result.exp  = exp_out;
      sum_result.frac = norm[FRAC_W-1:0];
    end
  end

endmodule

`default_nettype wire

//--- src/fpu_mul_seq.sv
// fpu multiplier: sequential shift-and-add mantissa product with sign and exponent
`timescale 1ns/1ps
`default_nettype none

module fpu_mul_seq (
  input  logic           clk,
  input  logic           arst,
  input  fpu_pkg::fp32_t operand_a,
  input  fpu_pkg::fp32_t operand_b,
  input  logic           mul_start,
  output fpu_pkg::fp32_t mul_result,
  output logic           mul_done
);
  import fpu_pkg::*;

  // product plus one carry bit
  localparam int PROD_W = 2 * MANT_W + 1;

  typedef enum logic [1:0] {
    ms_idle,
    ms_add,
    ms_shift,
    ms_norm
  } mul_state_e;

  mul_state_e        state;
  logic [4:0]        step;
  logic [MANT_W-1:0] multiplicand;
  logic [PROD_W-1:0] prod;
  logic              prod_sign;
  logic [7:0]        prod_exp;

  // sequencing, one add phase and one shift phase per multiplier bit
  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      state    <= ms_idle;
      step     <= '0;
      mul_done <= 1'b0;
    end else begin
      mul_done <= 1'b0;
      case (state)
        ms_idle: begin
          if (mul_start) begin
            state <= ms_add;
            step  <= '0;
          end
        end
        ms_add: begin
          state <= ms_shift;
          step  <= step + 5'd1;
        end
        ms_shift: begin
          if (step == 5'(MUL_STEPS)) begin
            state <= ms_norm;
          end else begin
            state <= ms_add;
          end
        end
        ms_norm: begin
          state    <= ms_idle;
          mul_done <= 1'b1;
        end
      endcase
    end
  end

  // datapath
  always_ff @(posedge clk) begin
    case (state)
      ms_idle: begin
        if (mul_start) begin
          multiplicand <= {|operand_a.exp, operand_a.frac};
          prod         <= {{(MANT_W + 1){1'b0}}, |operand_b.exp, operand_b.frac};
          prod_sign    <= operand_a.sign ^ operand_b.sign;
          prod_exp     <= operand_a.exp + operand_b.exp - 8'(EXP_BIAS);
        end
      end
      ms_add: begin
        if (prod[0]) begin
          prod[PROD_W-1:MANT_W] <= prod[PROD_W-1:MANT_W] + {1'b0, multiplicand};
        end
      end
      ms_shift: prod <= prod >> 1;
      ms_norm: begin
        mul_result.sign <= prod_sign;
        // product in [1,4), top bit set means 1x.xxx
        if (prod[2*MANT_W-1]) begin
          mul_result.exp  <= prod_exp + 8'd1;
          mul_result.frac <= prod[2*MANT_W-2 -: FRAC_W];
        end else begin
          mul_result.exp  <= prod_exp;
          mul_result.frac <= prod[2*MANT_W-3 -: FRAC_W];
        end
      end
    endcase
  end

  // the sequencer waits for mul_done before starting again
  mul_no_restart: assert property (@(posedge clk) disable iff (arst)
    mul_start |-> (state == ms_idle))
    else $error("mul_start while a multiplication is running");

endmodule

`default_nettype wire

//--- src/fpu_sequencer.sv
// fpu sequencer: command FSM, result select and host completion handshake
`timescale 1ns/1ps
`default_nettype none

module fpu_sequencer (
  input  logic             clk,
  input  logic             arst,
  input  fpu_pkg::fpu_op_e operation,
  input  logic             op_strobe,
  input  fpu_pkg::fp32_t   sum_result,
  input  fpu_pkg::fp32_t   mul_result,
  input  logic             mul_done,
  input  logic             end_ack,
  output logic             subtract,
  output logic             mul_start,
  output fpu_pkg::fp32_t   result,
  output logic             result_load,
  output logic             busy,
  output logic             cmd_end
);
  import fpu_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_execute,
    st_mul_wait,
    st_wait_ack
  } seq_state_e;

  seq_state_e state;
  logic       is_mul;

  assign is_mul    = (operation == op_mul);
  assign subtract  = (operation == op_sub);
  // execute lasts one cycle so this is a single pulse
  assign mul_start = (state == st_execute) && is_mul;

  // result select and load strobe
  always_comb begin
    result      = sum_result;
    result_load = 1'b0;
    if (state == st_execute) begin
      result_load = !is_mul;
      case (operation)
        op_k_pi:    result = K_PI;
        op_k_piby2: result = K_PI_BY_2;
        default:    result = sum_result;
      endcase
    end else if (state == st_mul_wait) begin
      result      = mul_result;
      result_load = mul_done;
    end
  end

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      state   <= st_idle;
      busy    <= 1'b0;
      cmd_end <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          // op writes outside idle only update the register
          if (op_strobe) begin
            state <= st_execute;
            busy  <= 1'b1;
          end
        end
        st_execute: begin
          if (is_mul) begin
            state <= st_mul_wait;
          end else begin
            state   <= st_wait_ack;
            cmd_end <= 1'b1;
          end
        end
        st_mul_wait: begin
          if (mul_done) begin
            state   <= st_wait_ack;
            cmd_end <= 1'b1;
          end
        end
        st_wait_ack: begin
          if (end_ack) begin
            state   <= st_idle;
            busy    <= 1'b0;
            cmd_end <= 1'b0;
          end
        end
      endcase
    end
  end

  // completion is only ever flagged inside a busy window
  cmd_end_in_busy: assert property (@(posedge clk) disable iff (arst)
    cmd_end |-> busy)
    else $error("cmd_end high without busy");

endmodule

`default_nettype wire

//--- src/fpu_top.sv
// fpu top: host bus registers, command sequencer, adder and multiplier
`timescale 1ns/1ps
`default_nettype none

module fpu_top (
  input  logic              clk,
  input  logic              arst,
  input  fpu_pkg::bus_req_t bus_req,
  input  logic              end_ack,
  output logic [7:0]        rdata,
  output logic              busy,
  output logic              cmd_end
);
  import fpu_pkg::*;

  fp32_t   operand_a;
  fp32_t   operand_b;
  fpu_op_e operation;
  logic    op_strobe;
  fp32_t   result;
  logic    result_load;
  logic    subtract;
  fp32_t   sum_result;
  logic    mul_start;
  fp32_t   mul_result;
  logic    mul_done;

  fpu_bus_regs i_bus_regs (
    .clk         (clk),
    .arst        (arst),
    .bus_req     (bus_req),
    .result      (result),
    .result_load (result_load),
    .rdata       (rdata),
    .operand_a   (operand_a),
    .operand_b   (operand_b),
    .operation   (operation),
    .op_strobe   (op_strobe)
  );

  fpu_sequencer i_sequencer (
    .clk         (clk),
    .arst        (arst),
    .operation   (operation),
    .op_strobe   (op_strobe),
    .sum_result  (sum_result),
    .mul_result  (mul_result),
    .mul_done    (mul_done),
    .end_ack     (end_ack),
    .subtract    (subtract),
    .mul_start   (mul_start),
    .result      (result),
    .result_load (result_load),
    .busy        (busy),
    .cmd_end     (cmd_end)
  );

  fpu_add_sub i_add_sub (
    .operand_a  (operand_a),
    .operand_b  (operand_b),
    .subtract   (subtract),
    .sum_result (sum_result)
  );

  fpu_mul_seq i_mul_seq (
    .clk        (clk),
    .arst       (arst),
    .operand_a  (operand_a),
    .operand_b  (operand_b),
    .mul_start  (mul_start),
    .mul_result (mul_result),
    .mul_done   (mul_done)
  );

endmodule

`default_nettype wire

//--- verif/fpu_tb.sv
// fpu testbench covering bus access, arithmetic, constants, completion handshake and chaining
`timescale 1ns/1ps
`default_nettype none

module fpu_tb;
  import fpu_pkg::*;

  localparam int RESET_CYCLES = 10;
  localparam int N_ADD_SUB    = 20;
  localparam int N_MUL        = 20;
  // random pairs, x minus x, one directed multiply, constants, chain, busy write
  localparam int N_OPS        = N_ADD_SUB + 1 + N_MUL + 1 + 2 + 3 + 1;
  localparam int WATCHDOG_CYC = N_OPS * 80 + RESET_CYCLES;
  localparam int DONE_TIMEOUT = 100;

  localparam bus_req_t BUS_IDLE = '{cs_n: 1'b1, rd_n: 1'b1, wr_n: 1'b1,
                                    addr: 4'h0, wdata: 8'h00};

  logic       clk;
  logic       arst;
  bus_req_t   bus_req;
  logic       end_ack;
  logic [7:0] rdata;
  logic       busy;
  logic       cmd_end;
  int         seed;

  fpu_top i_dut (
    .clk     (clk),
    .arst    (arst),
    .bus_req (bus_req),
    .end_ack (end_ack),
    .rdata   (rdata),
    .busy    (busy),
    .cmd_end (cmd_end)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic abort_run();
    $display("Regression failed");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic fail_value(input string msg);
    $display("FAIL %0t ns: %s", $time, msg);
    abort_run();
  endtask

  task automatic compare_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
    assert (got === exp)
      else fail_value($sformatf("%s: read %h, expected %h", what, got, exp));
  endtask

  // repacks the fields of an exactly representable double into single precision
  function automatic logic [31:0] real_to_fp32(input real value);
    logic [63:0] d;
    logic [10:0] e;
    if (value == 0.0) begin
      return 32'h0;
    end
    d = $realtobits(value);
    e = d[62:52];
    return {d[63], 8'(e - 11'd1023 + 11'd127), d[51:29]};
  endfunction

  // signed 8-bit integer scaled by a power of two
  function automatic real rand_value(input int max_shift);
    real v;
    int  k;
    v = real'($urandom_range(255, 1));
    k = int'($urandom_range(2 * max_shift, 0)) - max_shift;
    while (k > 0) begin
      v = v * 2.0;
      k--;
    end
    while (k < 0) begin
      v = v / 2.0;
      k++;
    end
    if ($urandom_range(1, 0) == 1) begin
      v = -v;
    end
    return v;
  endfunction

  task automatic release_bus();
    @(posedge clk);
    bus_req <= BUS_IDLE;
  endtask

  task automatic write_byte(input logic [3:0] addr, input logic [7:0] data);
    @(posedge clk);
    bus_req <= '{cs_n: 1'b0, rd_n: 1'b1, wr_n: 1'b0, addr: addr, wdata: data};
  endtask

  task automatic read_byte(input logic [3:0] addr, output logic [7:0] data);
    @(posedge clk);
    bus_req <= '{cs_n: 1'b0, rd_n: 1'b0, wr_n: 1'b1, addr: addr, wdata: 8'h00};
    @(negedge clk);
    data = rdata;
  endtask

  task automatic write_word(input logic [3:0] base, input logic [31:0] value);
    for (int i = 0; i < 4; i++) begin
      write_byte(base + 4'(i), value[8*i +: 8]);
    end
    release_bus();
  endtask

  task automatic read_word(input logic [3:0] base, output logic [31:0] value);
    logic [7:0] b;
    for (int i = 0; i < 4; i++) begin
      read_byte(base + 4'(i), b);
      value[8*i +: 8] = b;
    end
    release_bus();
  endtask

  // one command from op write to end_ack, then the result and operand A checks
  task automatic run_op(input string what, input logic [3:0] code,
                        input bit write_while_busy, input logic [31:0] expected);
    int          waited;
    int          delay;
    logic [31:0] got;
    logic [31:0] a_now;
    waited = 0;
    write_byte(ADDR_OP, {4'h0, code});
    release_bus();
    @(negedge clk);
    assert (!busy) else fail_value("busy high before the operation started");
    @(negedge clk);
    @(negedge clk);
    assert (busy) else fail_value("busy did not rise after an operation write");
    while (!cmd_end) begin
      if (waited == DONE_TIMEOUT) begin
        $display("cmd_end never rose after operation code %0d", code);
        abort_run();
      end
      @(negedge clk);
      waited++;
    end
    delay = $urandom_range(4, 0);
    repeat (delay) begin
      @(negedge clk);
      assert (cmd_end && busy) else fail_value("cmd_end or busy dropped before end_ack");
    end
    if (write_while_busy) begin
      write_byte(ADDR_OP, {4'h0, op_k_pi});
      release_bus();
      repeat (3) begin
        @(negedge clk);
        assert (cmd_end && busy) else fail_value("operation write while busy broke cmd_end");
      end
    end
    @(posedge clk);
    end_ack <= 1'b1;
    @(posedge clk);
    end_ack <= 1'b0;
    @(negedge clk);
    assert (!busy && !cmd_end) else fail_value("busy or cmd_end still high after end_ack");
    read_word(ADDR_R0, got);
    compare_word(what, got, expected);
    // result is copied into A on every completion
    read_word(ADDR_A0, a_now);
    compare_word($sformatf("%s, operand A", what), a_now, expected);
  endtask

  task automatic verify_reset_state();
    logic [31:0] word;
    logic [7:0]  op_byte;
    read_word(ADDR_A0, word);
    compare_word("A after reset", word, real_to_fp32(1.0));
    read_word(ADDR_B0, word);
    compare_word("B after reset", word, real_to_fp32(1.0));
    read_word(ADDR_R0, word);
    compare_word("result after reset", word, 32'h0);
    read_byte(ADDR_OP, op_byte);
    release_bus();
    compare_word("operation after reset", {24'h0, op_byte}, 32'h0);
    assert (!busy && !cmd_end) else fail_value("busy or cmd_end high after reset");
  endtask

  task automatic register_readback();
    logic [7:0] written [8];
    logic [7:0] got;
    for (int i = 0; i < 8; i++) begin
      written[i] = 8'($urandom_range(255, 0));
      write_byte(ADDR_A0 + 4'(i), written[i]);
    end
    release_bus();
    for (int i = 0; i < 8; i++) begin
      read_byte(ADDR_A0 + 4'(i), got);
      assert (got === written[i])
        else fail_value($sformatf("register byte %0d read %h, wrote %h", i, got, written[i]));
    end
    release_bus();
  endtask

  task automatic add_sub_sweep();
    real  a;
    real  b;
    logic sub;
    for (int i = 0; i < N_ADD_SUB; i++) begin
      a   = rand_value(4);
      b   = rand_value(4);
      sub = i[0];
      write_word(ADDR_A0, real_to_fp32(a));
      write_word(ADDR_B0, real_to_fp32(b));
      run_op($sformatf("%s pair %0d", sub ? "sub" : "add", i), sub ? op_sub : op_add,
             1'b0, real_to_fp32(sub ? a - b : a + b));
    end
    // exact cancellation
    a = rand_value(4);
    write_word(ADDR_A0, real_to_fp32(a));
    write_word(ADDR_B0, real_to_fp32(a));
    run_op("x minus x", op_sub, 1'b0, 32'h0);
  endtask

  task automatic multiply_sweep();
    real a;
    real b;
    for (int i = 0; i < N_MUL; i++) begin
      a = rand_value(4);
      b = rand_value(4);
      write_word(ADDR_A0, real_to_fp32(a));
      write_word(ADDR_B0, real_to_fp32(b));
      run_op($sformatf("mul pair %0d", i), op_mul, 1'b0, real_to_fp32(a * b));
    end
    // 1.5 times 1.5 carries into bit 47
    write_word(ADDR_A0, real_to_fp32(3.0));
    write_word(ADDR_B0, real_to_fp32(-3.0));
    run_op("mul 3 by -3", op_mul, 1'b0, real_to_fp32(-9.0));
  endtask

  task automatic constant_ops();
    write_word(ADDR_A0, real_to_fp32(rand_value(4)));
    write_word(ADDR_B0, real_to_fp32(rand_value(4)));
    run_op("pi", op_k_pi, 1'b0, real_to_fp32(3.141592653589793));
    run_op("pi/2", op_k_piby2, 1'b0, real_to_fp32(1.5707963267948966));
  endtask

  // only B is rewritten so A carries the previous result
  task automatic chained_ops();
    real acc;
    real b;
    acc = rand_value(0);
    b   = rand_value(0);
    write_word(ADDR_A0, real_to_fp32(acc));
    write_word(ADDR_B0, real_to_fp32(b));
    acc = acc * b;
    run_op("chain mul", op_mul, 1'b0, real_to_fp32(acc));
    b = rand_value(0);
    write_word(ADDR_B0, real_to_fp32(b));
    acc = acc + b;
    run_op("chain add", op_add, 1'b0, real_to_fp32(acc));
    b = rand_value(0);
    write_word(ADDR_B0, real_to_fp32(b));
    acc = acc - b;
    run_op("chain sub", op_sub, 1'b0, real_to_fp32(acc));
  endtask

  task automatic busy_op_write();
    real        a;
    real        b;
    logic [7:0] op_byte;
    a = rand_value(4);
    b = rand_value(4);
    write_word(ADDR_A0, real_to_fp32(a));
    write_word(ADDR_B0, real_to_fp32(b));
    run_op("add with op write while busy", op_add, 1'b1, real_to_fp32(a + b));
    repeat (6) begin
      @(negedge clk);
      assert (!busy && !cmd_end) else fail_value("op write while busy started a command");
    end
    read_byte(ADDR_OP, op_byte);
    release_bus();
    compare_word("operation written while busy", {24'h0, op_byte}, {28'h0, op_k_pi});
  endtask

  cmd_end_needs_busy: assert property (@(posedge clk) disable iff (arst)
    cmd_end |-> busy)
    else fail_value("cmd_end high while busy is low");

  cmd_end_held: assert property (@(posedge clk) disable iff (arst)
    (cmd_end && !end_ack) |=> cmd_end)
    else fail_value("cmd_end fell without end_ack");

  ack_clears_both: assert property (@(posedge clk) disable iff (arst)
    (cmd_end && end_ack) |=> (!busy && !cmd_end))
    else fail_value("busy or cmd_end survived the end_ack edge");

  rdata_zero_idle: assert property (@(posedge clk) disable iff (arst)
    (bus_req.cs_n || bus_req.rd_n) |-> (rdata == 8'h00))
    else fail_value("rdata not zero without a read");

  initial begin
    repeat (WATCHDOG_CYC) @(posedge clk);
    $display("run hung: tests did not finish within %0d cycles", WATCHDOG_CYC);
    abort_run();
  end

  initial begin
    seed    = $urandom(24499);
    arst    = 1'b1;
    end_ack = 1'b0;
    bus_req = BUS_IDLE;
    repeat (RESET_CYCLES) @(posedge clk);
    arst <= 1'b0;
    verify_reset_state();
    register_readback();
    add_sub_sweep();
    multiply_sweep();
    constant_ops();
    chained_ops();
    busy_op_write();
    @(posedge clk);
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
src/fpu_pkg.sv
src/fpu_bus_regs.sv
src/fpu_add_sub.sv
src/fpu_mul_seq.sv
src/fpu_sequencer.sv
src/fpu_top.sv
verif/fpu_tb.sv

//--- Makefile
TOP := fpu_tb
OBJ := obj_dir

.PHONY: all run lint clean

all: run

$(OBJ)/V$(TOP): list.f src/*.sv verif/*.sv
	verilator --binary --timing --assert -j 0 -f list.f --top-module $(TOP) -Mdir $(OBJ)

run: $(OBJ)/V$(TOP)
	./$(OBJ)/V$(TOP)

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

clean:
	rm -rf $(OBJ)
